// File: flist.f
hdl/vinstr_pkg.sv
hdl/ist_pkg.sv
hdl/ist_if.sv
hdl/instr_status_table.sv
hdl/operand_read_stage.sv
hdl/writeback_stage.sv
hdl/vec_sequencer.sv
tb/seq_checker.sv
tb/tb_vec_sequencer.sv

// File: hdl/instr_status_table.sv
`timescale 1ns/1ps

module instr_status_table
    import vinstr_pkg::*;
    import ist_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       instr_valid,
    input  ist_entry_t new_entry,
    output logic       full,
    ist_if.tbl         ist
);

    ist_entry_t         slots [NUM_SLOTS];
    // one spare entry on top feeds the shift with an empty slot
    ist_entry_t         upd   [NUM_SLOTS+1];
    ist_entry_t         nxt   [NUM_SLOTS];
    logic [COUNT_W-1:0] count;
    logic [COUNT_W-1:0] alloc_pos;
    logic               accept;

    assign full        = (count == COUNT_W'(NUM_SLOTS));
    assign accept      = instr_valid && !full;
    assign ist.entries = slots;

    // slot index after this cycle's retirement
    assign alloc_pos = ist.retire_en ? count - 1'b1 : count;

    always_comb begin
        // state changes, indexed by the current positions
        for (int i = 0; i < NUM_SLOTS; i++) begin
            upd[i] = slots[i];
            if (slots[i].state == ST_ISSUE) begin
                upd[i].state = ST_READ;
            end
        end
        upd[NUM_SLOTS] = '0;
        if (ist.dispatch_en) begin
            upd[ist.dispatch_idx].state = ST_EXEC;
        end
        for (int u = 0; u < NUM_FU; u++) begin
            if (ist.done_en[u]) begin
                upd[ist.done_idx[u]].state = ST_WB;
            end
        end

        // close the gap left by the retired slot
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (ist.retire_en && i >= int'(ist.retire_idx)) begin
                nxt[i] = upd[i+1];
            end else begin
                nxt[i] = upd[i];
            end
        end

        if (accept) begin
            nxt[alloc_pos[SLOT_IDX_W-1:0]]       = new_entry;
            nxt[alloc_pos[SLOT_IDX_W-1:0]].state = ST_ISSUE;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            count <= '0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else begin
            count <= count + COUNT_W'(accept) - COUNT_W'(ist.retire_en);
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= nxt[i];
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!nrst)
        count <= COUNT_W'(NUM_SLOTS));

    a_retire_live: assert property (@(posedge clk) disable iff (!nrst)
        ist.retire_en |-> slots[ist.retire_idx].state != ST_EMPTY);

    for (genvar u = 0; u < NUM_FU; u++) begin : g_done_chk
        a_done_live: assert property (@(posedge clk) disable iff (!nrst)
            ist.done_en[u] |-> slots[ist.done_idx[u]].state != ST_EMPTY);
    end

endmodule

// File: hdl/ist_if.sv
`timescale 1ns/1ps

interface ist_if
    import vinstr_pkg::*;
    import ist_pkg::*;
();

    ist_entry_t            entries [NUM_SLOTS];

    // one-cycle strobes, applied by the table at the next edge
    logic                  dispatch_en;
    logic [SLOT_IDX_W-1:0] dispatch_idx;
    // one strobe per unit, index 0 is ALU
    logic [NUM_FU-1:0]     done_en;
    logic [SLOT_IDX_W-1:0] done_idx [NUM_FU];
    logic                  retire_en;
    logic [SLOT_IDX_W-1:0] retire_idx;

    modport tbl (
        output entries,
        input  dispatch_en, dispatch_idx,
        input  done_en, done_idx,
        input  retire_en, retire_idx
    );

    modport reader (
        input  entries,
        output dispatch_en, dispatch_idx
    );

    modport retirer (
        input  entries,
        output done_en, done_idx,
        output retire_en, retire_idx
    );

endinterface

// File: hdl/ist_pkg.sv
package ist_pkg;

    import vinstr_pkg::*;

    localparam int NUM_SLOTS  = 8;
    localparam int SLOT_IDX_W = 3;
    localparam int COUNT_W    = 4;

    // slot lifetime, in order
    typedef enum logic [2:0] {
        ST_EMPTY = 3'd0,
        ST_ISSUE = 3'd1,
        ST_READ  = 3'd2,
        ST_EXEC  = 3'd3,
        ST_WB    = 3'd4
    } slot_state_e;

    typedef struct packed {
        slot_state_e           state;
        fu_e                   fu;
        logic [OP_W-1:0]       op;
        logic [VSEW_W-1:0]     vsew;
        logic [LMUL_W-1:0]     lmul;
        src_sel_e              sel_op_a;
        src_sel_e              sel_op_b;
        dest_sel_e             sel_dest;
        logic [VREG_W-1:0]     src_a;
        logic [VREG_W-1:0]     src_b;
        logic [VREG_W-1:0]     dest;
        logic [IMM_W-1:0]      imm;
    } ist_entry_t;

endpackage

// File: hdl/operand_read_stage.sv
`timescale 1ns/1ps

module operand_read_stage
    import vinstr_pkg::*;
    import ist_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    ist_if.reader             ist,
    output logic              disp_valid,
    output fu_e               disp_fu,
    output logic [OP_W-1:0]   disp_op,
    output logic [VSEW_W-1:0] disp_vsew,
    output logic [LMUL_W-1:0] disp_lmul,
    output logic [VREG_W-1:0] disp_src_a,
    output logic [VREG_W-1:0] disp_src_b,
    output logic [IMM_W-1:0]  disp_imm
);

    logic                  rd_found;
    logic [SLOT_IDX_W-1:0] rd_idx;
    ist_entry_t            rd_entry;
    logic                  unit_busy;
    logic                  raw_hit;
    logic                  go;
    logic [NUM_SLOTS-1:0]  exec_mask;

    // oldest slot waiting for operands
    always_comb begin
        rd_found = 1'b0;
        rd_idx   = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (ist.entries[i].state == ST_READ) begin
                rd_found = 1'b1;
                rd_idx   = SLOT_IDX_W'(i);
            end
        end
    end

    assign rd_entry = ist.entries[rd_idx];

    // unit still owned by an in-flight slot, or a pending vector write
    always_comb begin
        unit_busy = 1'b0;
        raw_hit   = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (ist.entries[i].state inside {ST_EXEC, ST_WB}) begin
                if (ist.entries[i].fu == rd_entry.fu) begin
                    unit_busy = 1'b1;
                end
                if (i < int'(rd_idx) && ist.entries[i].sel_dest == DEST_VREG) begin
                    if (reads_vreg(rd_entry.sel_op_a) &&
                        ist.entries[i].dest == rd_entry.src_a) begin
                        raw_hit = 1'b1;
                    end
                    if (reads_vreg(rd_entry.sel_op_b) &&
                        ist.entries[i].dest == rd_entry.src_b) begin
                        raw_hit = 1'b1;
                    end
                end
            end
        end
    end

    assign go = rd_found && (rd_entry.fu != FU_NONE) && !unit_busy && !raw_hit;

    assign ist.dispatch_en  = go;
    assign ist.dispatch_idx = rd_idx;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= go;
        end
    end

    // dispatch bus, each unit latches it on disp_valid
    always_ff @(posedge clk) begin
        if (go) begin
            disp_fu    <= rd_entry.fu;
            disp_op    <= rd_entry.op;
            disp_vsew  <= rd_entry.vsew;
            disp_lmul  <= rd_entry.lmul;
            disp_src_a <= rd_entry.src_a;
            disp_src_b <= rd_entry.src_b;
            disp_imm   <= rd_entry.imm;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            exec_mask[i] = (ist.entries[i].state == ST_EXEC) &&
                           (ist.entries[i].fu == disp_fu);
        end
    end

    // the dispatched slot is the only one executing on that unit
    a_one_exec: assert property (@(posedge clk) disable iff (!nrst)
        disp_valid |-> $onehot(exec_mask));

endmodule

// File: hdl/vec_sequencer.sv
`timescale 1ns/1ps

module vec_sequencer
    import vinstr_pkg::*;
    import ist_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,

    // decoded instruction
    input  logic              instr_valid,
    input  dest_sel_e         sel_dest,
    input  logic [VSEW_W-1:0] vsew,
    input  logic [LMUL_W-1:0] lmul,
    input  src_sel_e          sel_op_a,
    input  src_sel_e          sel_op_b,
    input  fu_e               fu_sel,
    input  logic [OP_W-1:0]   op,
    input  logic [VREG_W-1:0] src_a,
    input  logic [VREG_W-1:0] src_b,
    input  logic [VREG_W-1:0] dest,
    input  logic [IMM_W-1:0]  imm,
    output logic              full,

    // dispatch bus to the units
    output logic              disp_valid,
    output fu_e               disp_fu,
    output logic [OP_W-1:0]   disp_op,
    output logic [VSEW_W-1:0] disp_vsew,
    output logic [LMUL_W-1:0] disp_lmul,
    output logic [VREG_W-1:0] disp_src_a,
    output logic [VREG_W-1:0] disp_src_b,
    output logic [IMM_W-1:0]  disp_imm,

    // unit completion
    input  logic              done_alu,
    input  logic              done_mul,
    input  logic              done_lsu,
    input  logic [DATA_W-1:0] result_alu,
    input  logic [DATA_W-1:0] result_mul,
    input  logic [DATA_W-1:0] result_lsu,

    // register file write
    output logic              v_reg_wr_en,
    output logic              x_reg_wr_en,
    output logic [VREG_W-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data
);

    ist_entry_t new_entry;

    always_comb begin
        new_entry.state    = ST_ISSUE;
        new_entry.fu       = fu_sel;
        new_entry.op       = op;
        new_entry.vsew     = vsew;
        new_entry.lmul     = lmul;
        new_entry.sel_op_a = sel_op_a;
        new_entry.sel_op_b = sel_op_b;
        new_entry.sel_dest = sel_dest;
        new_entry.src_a    = src_a;
        new_entry.src_b    = src_b;
        new_entry.dest     = dest;
        new_entry.imm      = imm;
    end

    ist_if u_ist ();

    instr_status_table u_table (
        .clk         (clk),
        .nrst        (nrst),
        .instr_valid (instr_valid),
        .new_entry   (new_entry),
        .full        (full),
        .ist         (u_ist.tbl)
    );

    operand_read_stage u_read (
        .clk        (clk),
        .nrst       (nrst),
        .ist        (u_ist.reader),
        .disp_valid (disp_valid),
        .disp_fu    (disp_fu),
        .disp_op    (disp_op),
        .disp_vsew  (disp_vsew),
        .disp_lmul  (disp_lmul),
        .disp_src_a (disp_src_a),
        .disp_src_b (disp_src_b),
        .disp_imm   (disp_imm)
    );

    writeback_stage u_wb (
        .clk         (clk),
        .nrst        (nrst),
        .ist         (u_ist.retirer),
        .done_alu    (done_alu),
        .done_mul    (done_mul),
        .done_lsu    (done_lsu),
        .result_alu  (result_alu),
        .result_mul  (result_mul),
        .result_lsu  (result_lsu),
        .v_reg_wr_en (v_reg_wr_en),
        .x_reg_wr_en (x_reg_wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

endmodule

// File: hdl/vinstr_pkg.sv
package vinstr_pkg;

    // field widths of a decoded vector instruction
    localparam int VREG_W = 5;
    localparam int OP_W   = 4;
    localparam int VSEW_W = 2;
    localparam int LMUL_W = 2;
    localparam int IMM_W  = 5;
    localparam int DATA_W = 128;

    // ALU, MUL and LSU
    localparam int NUM_FU = 3;

    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_MUL  = 2'd2,
        FU_LSU  = 2'd3
    } fu_e;

    typedef enum logic [1:0] {
        SRC_VREG   = 2'd0,
        SRC_VREG2  = 2'd1,
        SRC_SCALAR = 2'd2,
        SRC_IMM    = 2'd3
    } src_sel_e;

    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_VREG = 2'd1,
        DEST_XREG = 2'd2
    } dest_sel_e;

    typedef enum logic [3:0] {
        LSU_NOP           = 4'd0,
        LSU_LOAD_UNIT     = 4'd4,
        LSU_LOAD_STRIDED  = 4'd5,
        LSU_LOAD_INDEXED  = 4'd6,
        LSU_STORE_UNIT    = 4'd7,
        LSU_STORE_STRIDED = 4'd8,
        LSU_STORE_INDEXED = 4'd9
    } lsu_op_e;

    // stores go to memory only
    function automatic logic is_lsu_store(logic [OP_W-1:0] op);
        return (op == LSU_STORE_UNIT) || (op == LSU_STORE_STRIDED) ||
               (op == LSU_STORE_INDEXED);
    endfunction

    function automatic logic reads_vreg(src_sel_e sel);
        return (sel == SRC_VREG) || (sel == SRC_VREG2);
    endfunction

endpackage

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import vinstr_pkg::*;
    import ist_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    ist_if.retirer            ist,
    input  logic              done_alu,
    input  logic              done_mul,
    input  logic              done_lsu,
    input  logic [DATA_W-1:0] result_alu,
    input  logic [DATA_W-1:0] result_mul,
    input  logic [DATA_W-1:0] result_lsu,
    output logic              v_reg_wr_en,
    output logic              x_reg_wr_en,
    output logic [VREG_W-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data
);

    logic                  done_in    [NUM_FU];
    logic [DATA_W-1:0]     result_in  [NUM_FU];
    logic [DATA_W-1:0]     result_buf [NUM_FU];
    logic                  exec_found [NUM_FU];
    logic [SLOT_IDX_W-1:0] exec_idx   [NUM_FU];
    ist_entry_t            wb_entry;
    logic                  wb_store;
    logic [DATA_W-1:0]     wb_data;

    // unit order matches fu_e minus one
    assign done_in[0]   = done_alu;
    assign done_in[1]   = done_mul;
    assign done_in[2]   = done_lsu;
    assign result_in[0] = result_alu;
    assign result_in[1] = result_mul;
    assign result_in[2] = result_lsu;

    // at most one slot per unit is executing
    always_comb begin
        for (int u = 0; u < NUM_FU; u++) begin
            exec_found[u] = 1'b0;
            exec_idx[u]   = '0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (ist.entries[i].state == ST_EXEC &&
                    ist.entries[i].fu == fu_e'(u + 1)) begin
                    exec_found[u] = 1'b1;
                    exec_idx[u]   = SLOT_IDX_W'(i);
                end
            end
            ist.done_en[u]  = done_in[u] && exec_found[u];
            ist.done_idx[u] = exec_idx[u];
        end
    end

    // result holds until the slot retires, unit stays busy till then
    always_ff @(posedge clk) begin
        for (int u = 0; u < NUM_FU; u++) begin
            if (done_in[u]) begin
                result_buf[u] <= result_in[u];
            end
        end
    end

    // oldest slot in write back
    always_comb begin
        ist.retire_en  = 1'b0;
        ist.retire_idx = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (ist.entries[i].state == ST_WB) begin
                ist.retire_en  = 1'b1;
                ist.retire_idx = SLOT_IDX_W'(i);
            end
        end
    end

    assign wb_entry = ist.entries[ist.retire_idx];
    assign wb_store = (wb_entry.fu == FU_LSU) && is_lsu_store(wb_entry.op);

    always_comb begin
        case (wb_entry.fu)
            FU_MUL:  wb_data = result_buf[1];
            FU_LSU:  wb_data = result_buf[2];
            default: wb_data = result_buf[0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            v_reg_wr_en <= 1'b0;
            x_reg_wr_en <= 1'b0;
        end else begin
            v_reg_wr_en <= ist.retire_en && (wb_entry.sel_dest == DEST_VREG) && !wb_store;
            x_reg_wr_en <= ist.retire_en && (wb_entry.sel_dest == DEST_XREG);
        end
    end

    always_ff @(posedge clk) begin
        if (ist.retire_en) begin
            wr_addr <= wb_entry.dest;
            wr_data <= wb_data;
        end
    end

    a_one_port: assert property (@(posedge clk) disable iff (!nrst)
        !(v_reg_wr_en && x_reg_wr_en));

    for (genvar u = 0; u < NUM_FU; u++) begin : g_done_chk
        // a unit only finishes work that was dispatched to it
        a_done_match: assert property (@(posedge clk) disable iff (!nrst)
            done_in[u] |-> exec_found[u]);
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the vec_sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vec_sequencer -f flist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: tb/seq_checker.sv
`timescale 1ns/1ps

module seq_checker
    import vinstr_pkg::*;
#(
    parameter int NROWS = 13
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              full,
    input  logic              disp_valid,
    input  fu_e               disp_fu,
    input  logic [OP_W-1:0]   disp_op,
    input  logic [VSEW_W-1:0] disp_vsew,
    input  logic [LMUL_W-1:0] disp_lmul,
    input  logic [VREG_W-1:0] disp_src_a,
    input  logic [VREG_W-1:0] disp_src_b,
    input  logic [IMM_W-1:0]  disp_imm,
    input  logic              done_alu,
    input  logic              done_mul,
    input  logic              done_lsu,
    input  logic              v_reg_wr_en,
    input  logic              x_reg_wr_en,
    input  logic [VREG_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    output int                errors,
    output logic              all_done
);

    int   row_err  [NROWS];
    logic finished [NROWS];
    logic retired  [NROWS];
    int   unit_row [3];
    int   disp_cnt;
    int   n_retired;
    int   n_pass;
    int   n_fail;
    logic saw_full;

    assign all_done = (n_retired == NROWS);

    function automatic logic [DATA_W-1:0] expected_data(int row, int fu);
        return {8'(fu), 24'hC0FFEE, 64'h0123456789ABCDEF, 32'(row)};
    endfunction

    function automatic logic is_store_row(int k);
        logic [OP_W-1:0] o;
        o = tb_vec_sequencer.row_op[k];
        return tb_vec_sequencer.row_fu[k] == FU_LSU &&
               (o == LSU_STORE_UNIT || o == LSU_STORE_STRIDED || o == LSU_STORE_INDEXED);
    endfunction

    function automatic logic wants_vwrite(int k);
        return tb_vec_sequencer.row_sd[k] == DEST_VREG && !is_store_row(k);
    endfunction

    function automatic logic wants_xwrite(int k);
        return tb_vec_sequencer.row_sd[k] == DEST_XREG;
    endfunction

    function automatic logic is_vsrc(src_sel_e s);
        return s == SRC_VREG || s == SRC_VREG2;
    endfunction

    task automatic compare_field(int row, string name, logic [DATA_W-1:0] got,
                                 logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR row %0d %s: got %h expected %h", row, name, got, exp);
            row_err[row]++;
            errors++;
        end
    endtask

    task automatic report_problem(int row, string what);
        $display("row %0d: %s", row, what);
        if (row >= 0 && row < NROWS) begin
            row_err[row]++;
        end
        errors++;
    endtask

    task automatic finish_row(int k);
        retired[k] = 1'b1;
        n_retired++;
        if (row_err[k] == 0) begin
            n_pass++;
            $display("row %0d retired, ok", k);
        end else begin
            n_fail++;
            $display("row %0d retired, %0d errors", k, row_err[k]);
        end
    endtask

    task automatic check_dispatch();
        int k;
        int u;
        k = disp_cnt;
        disp_cnt++;
        if (k >= NROWS) begin
            report_problem(-1, "dispatch beyond the last table row");
            return;
        end
        compare_field(k, "disp_fu", disp_fu, tb_vec_sequencer.row_fu[k]);
        compare_field(k, "disp_op", disp_op, tb_vec_sequencer.row_op[k]);
        compare_field(k, "disp_vsew", disp_vsew, tb_vec_sequencer.row_vsew[k]);
        compare_field(k, "disp_lmul", disp_lmul, tb_vec_sequencer.row_lmul[k]);
        compare_field(k, "disp_src_a", disp_src_a, tb_vec_sequencer.row_srca[k]);
        compare_field(k, "disp_src_b", disp_src_b, tb_vec_sequencer.row_srcb[k]);
        compare_field(k, "disp_imm", disp_imm, tb_vec_sequencer.row_imm[k]);
        // older writer of a source register must be written back first
        for (int j = 0; j < k; j++) begin
            if (wants_vwrite(j) && !retired[j] &&
                ((is_vsrc(tb_vec_sequencer.row_sa[k]) &&
                  tb_vec_sequencer.row_srca[k] == tb_vec_sequencer.row_dest[j]) ||
                 (is_vsrc(tb_vec_sequencer.row_sb[k]) &&
                  tb_vec_sequencer.row_srcb[k] == tb_vec_sequencer.row_dest[j]))) begin
                report_problem(k, $sformatf("dispatched before row %0d wrote its source", j));
            end
        end
        u = int'(tb_vec_sequencer.row_fu[k]) - 1;
        if (unit_row[u] >= 0 && !retired[unit_row[u]]) begin
            report_problem(k, "dispatched to a unit that is still busy");
        end
        unit_row[u] = k;
    endtask

    task automatic unit_done(int u);
        int r;
        r = unit_row[u];
        if (r < 0) begin
            report_problem(-1, "unit done pulse with nothing dispatched");
            return;
        end
        finished[r] = 1'b1;
        if (!wants_vwrite(r) && !wants_xwrite(r)) begin
            finish_row(r);
        end
    endtask

    task automatic check_write();
        int k;
        k = -1;
        if (v_reg_wr_en && x_reg_wr_en) begin
            report_problem(-1, "vector and scalar write enables high together");
        end
        for (int j = 0; j < NROWS; j++) begin
            if (tb_vec_sequencer.row_dest[j] == wr_addr &&
                (v_reg_wr_en ? wants_vwrite(j) : wants_xwrite(j))) begin
                k = j;
            end
        end
        if (k < 0) begin
            $display("ERR wr_addr: %h matches no row expecting this write", wr_addr);
            errors++;
        end else if (retired[k]) begin
            report_problem(k, "written back a second time");
        end else begin
            if (!finished[k]) begin
                report_problem(k, "written back before its unit finished");
            end
            compare_field(k, "wr_data", wr_data,
                          expected_data(k, int'(tb_vec_sequencer.row_fu[k])));
            finish_row(k);
        end
    endtask

    task automatic final_check();
        if (disp_cnt != NROWS) begin
            report_problem(-1, $sformatf("%0d dispatches seen for %0d rows", disp_cnt, NROWS));
        end
        if (n_retired != NROWS) begin
            report_problem(-1, "not every row retired");
        end
        if (!saw_full) begin
            report_problem(-1, "the table never reported full");
        end
        if (tb_vec_sequencer.DUT.u_table.count != 0) begin
            report_problem(-1, "the table did not drain");
        end
        $display("rows %0d, passed %0d, failed %0d, errors %0d",
                 NROWS, n_pass, n_fail, errors);
    endtask

    initial begin
        errors    = 0;
        disp_cnt  = 0;
        n_retired = 0;
        n_pass    = 0;
        n_fail    = 0;
        saw_full  = 1'b0;
        for (int u = 0; u < 3; u++) begin
            unit_row[u] = -1;
        end
        for (int k = 0; k < NROWS; k++) begin
            row_err[k]  = 0;
            finished[k] = 1'b0;
            retired[k]  = 1'b0;
        end
    end

    // registered DUT outputs are settled by the falling edge
    always @(negedge clk) begin
        if (nrst) begin
            if (full) begin
                saw_full = 1'b1;
            end
            if (done_alu) unit_done(0);
            if (done_mul) unit_done(1);
            if (done_lsu) unit_done(2);
            if (v_reg_wr_en || x_reg_wr_en) begin
                check_write();
            end
            if (disp_valid) begin
                check_dispatch();
            end
        end
    end

endmodule

// File: tb/tb_vec_sequencer.sv
`timescale 1ns/1ps

module tb_vec_sequencer
    import vinstr_pkg::*;
();

    localparam int NROWS = 13;
    localparam int LIMIT = NROWS * (6 + 8) + 100;

    logic              clk;
    logic              nrst;
    logic              instr_valid;
    dest_sel_e         sel_dest;
    logic [VSEW_W-1:0] vsew;
    logic [LMUL_W-1:0] lmul;
    src_sel_e          sel_op_a;
    src_sel_e          sel_op_b;
    fu_e               fu_sel;
    logic [OP_W-1:0]   op;
    logic [VREG_W-1:0] src_a;
    logic [VREG_W-1:0] src_b;
    logic [VREG_W-1:0] dest;
    logic [IMM_W-1:0]  imm;
    logic              full;
    logic              disp_valid;
    fu_e               disp_fu;
    logic [OP_W-1:0]   disp_op;
    logic [VSEW_W-1:0] disp_vsew;
    logic [LMUL_W-1:0] disp_lmul;
    logic [VREG_W-1:0] disp_src_a;
    logic [VREG_W-1:0] disp_src_b;
    logic [IMM_W-1:0]  disp_imm;
    logic              v_reg_wr_en;
    logic              x_reg_wr_en;
    logic [VREG_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;

    // stimulus table, one entry per row
    fu_e               row_fu   [NROWS];
    logic [OP_W-1:0]   row_op   [NROWS];
    src_sel_e          row_sa   [NROWS];
    src_sel_e          row_sb   [NROWS];
    dest_sel_e         row_sd   [NROWS];
    logic [VREG_W-1:0] row_srca [NROWS];
    logic [VREG_W-1:0] row_srcb [NROWS];
    logic [VREG_W-1:0] row_dest [NROWS];
    logic [IMM_W-1:0]  row_imm  [NROWS];
    logic [VSEW_W-1:0] row_vsew [NROWS];
    logic [LMUL_W-1:0] row_lmul [NROWS];
    int                row_dly  [NROWS];
    int                row_gap  [NROWS];

    // functional unit models, index 0 is ALU
    logic              done_v   [3];
    logic [DATA_W-1:0] res_v    [3];
    logic              pend     [3];
    int                pend_row [3];
    int                wait_cnt [3];
    int                disp_seen;
    int                seed;
    int                cycles;
    int                errors;
    logic              all_done;

    vec_sequencer DUT (
        .clk (clk), .nrst (nrst), .instr_valid (instr_valid),
        .sel_dest (sel_dest), .vsew (vsew), .lmul (lmul),
        .sel_op_a (sel_op_a), .sel_op_b (sel_op_b), .fu_sel (fu_sel),
        .op (op), .src_a (src_a), .src_b (src_b), .dest (dest), .imm (imm),
        .full (full), .disp_valid (disp_valid), .disp_fu (disp_fu),
        .disp_op (disp_op), .disp_vsew (disp_vsew), .disp_lmul (disp_lmul),
        .disp_src_a (disp_src_a), .disp_src_b (disp_src_b), .disp_imm (disp_imm),
        .done_alu (done_v[0]), .done_mul (done_v[1]), .done_lsu (done_v[2]),
        .result_alu (res_v[0]), .result_mul (res_v[1]), .result_lsu (res_v[2]),
        .v_reg_wr_en (v_reg_wr_en), .x_reg_wr_en (x_reg_wr_en),
        .wr_addr (wr_addr), .wr_data (wr_data)
    );

    seq_checker #(.NROWS(NROWS)) CHK (
        .clk (clk), .nrst (nrst), .full (full), .disp_valid (disp_valid),
        .disp_fu (disp_fu), .disp_op (disp_op), .disp_vsew (disp_vsew),
        .disp_lmul (disp_lmul), .disp_src_a (disp_src_a), .disp_src_b (disp_src_b),
        .disp_imm (disp_imm), .done_alu (done_v[0]), .done_mul (done_v[1]),
        .done_lsu (done_v[2]), .v_reg_wr_en (v_reg_wr_en), .x_reg_wr_en (x_reg_wr_en),
        .wr_addr (wr_addr), .wr_data (wr_data), .errors (errors), .all_done (all_done)
    );

    always #4 clk = ~clk;

    // fixed tag in the upper bits, row number in the low word
    function automatic logic [DATA_W-1:0] tagged_result(int row, int fu);
        return {8'(fu), 24'hC0FFEE, 64'h0123456789ABCDEF, 32'(row)};
    endfunction

    // dly of zero means a random unit delay
    task automatic add_row(int k, fu_e f, logic [OP_W-1:0] o, src_sel_e sa, src_sel_e sb,
                           dest_sel_e sd, int ra, int rb, int rd, int im, int dly, int gap);
        row_fu[k]   = f;
        row_op[k]   = o;
        row_sa[k]   = sa;
        row_sb[k]   = sb;
        row_sd[k]   = sd;
        row_srca[k] = VREG_W'(ra);
        row_srcb[k] = VREG_W'(rb);
        row_dest[k] = VREG_W'(rd);
        row_imm[k]  = IMM_W'(im);
        row_vsew[k] = VSEW_W'(k % 4);
        row_lmul[k] = LMUL_W'((k / 4) % 4);
        row_dly[k]  = (dly > 0) ? dly : 1 + int'($unsigned($random(seed)) % 6);
        row_gap[k]  = gap;
    endtask

    task automatic drive_row(int k);
        instr_valid = 1'b1;
        fu_sel      = row_fu[k];
        op          = row_op[k];
        sel_op_a    = row_sa[k];
        sel_op_b    = row_sb[k];
        sel_dest    = row_sd[k];
        src_a       = row_srca[k];
        src_b       = row_srcb[k];
        dest        = row_dest[k];
        imm         = row_imm[k];
        vsew        = row_vsew[k];
        lmul        = row_lmul[k];
    endtask

    // a unit picks up its row from the dispatch bus
    always @(negedge clk) begin
        int u;
        if (nrst && disp_valid && disp_fu != FU_NONE && disp_seen < NROWS) begin
            u = int'(disp_fu) - 1;
            pend[u]     = 1'b1;
            pend_row[u] = disp_seen;
            wait_cnt[u] = row_dly[disp_seen] - 1;
            disp_seen   = disp_seen + 1;
        end
    end

    always @(posedge clk) begin
        #1;
        for (int u = 0; u < 3; u++) begin
            done_v[u] = 1'b0;
            if (pend[u]) begin
                if (wait_cnt[u] == 0) begin
                    done_v[u] = 1'b1;
                    res_v[u]  = tagged_result(pend_row[u], u + 1);
                    pend[u]   = 1'b0;
                end else begin
                    wait_cnt[u] = wait_cnt[u] - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        nrst        = 1'b0;
        instr_valid = 1'b0;
        sel_dest    = DEST_NONE;
        vsew        = '0;
        lmul        = '0;
        sel_op_a    = SRC_VREG;
        sel_op_b    = SRC_VREG;
        fu_sel      = FU_NONE;
        op          = '0;
        src_a       = '0;
        src_b       = '0;
        dest        = '0;
        imm         = '0;
        disp_seen   = 0;
        cycles      = 0;
        seed        = 32'h5d875535;
        for (int u = 0; u < 3; u++) begin
            done_v[u] = 1'b0;
            res_v[u]  = '0;
            pend[u]   = 1'b0;
        end

        //      row  fu      op  src a       src b       dest       ra rb rd  imm dly gap
        add_row(0,  FU_ALU, 4'd1, SRC_VREG,   SRC_VREG,  DEST_VREG, 1, 2, 10, 0,  5, 0);
        // waits for v10
        add_row(1,  FU_MUL, 4'd2, SRC_VREG,   SRC_VREG2, DEST_VREG, 10, 3, 11, 0, 0, 0);
        add_row(2,  FU_LSU, LSU_STORE_UNIT, SRC_SCALAR, SRC_IMM, DEST_VREG, 10, 11, 12, 7, 0, 1);
        add_row(3,  FU_ALU, 4'd3, SRC_VREG,   SRC_VREG,  DEST_XREG, 3, 4, 13, 0,  0, 3);
        // long multiply, fills the table behind it
        add_row(4,  FU_MUL, 4'd2, SRC_VREG,   SRC_VREG,  DEST_VREG, 5, 6, 14, 0, 40, 0);
        add_row(5,  FU_MUL, 4'd5, SRC_VREG,   SRC_SCALAR, DEST_VREG, 7, 1, 15, 0, 0, 0);
        add_row(6,  FU_ALU, 4'd1, SRC_VREG,   SRC_VREG,  DEST_VREG, 14, 2, 16, 0, 0, 0);
        add_row(7,  FU_LSU, LSU_LOAD_UNIT, SRC_SCALAR, SRC_IMM, DEST_VREG, 2, 0, 17, 3, 0, 0);
        add_row(8,  FU_ALU, 4'd6, SRC_IMM,    SRC_IMM,   DEST_VREG, 14, 15, 18, 9, 0, 0);
        add_row(9,  FU_LSU, LSU_STORE_STRIDED, SRC_VREG, SRC_SCALAR, DEST_NONE, 8, 4, 0, 0, 0, 0);
        add_row(10, FU_ALU, 4'd7, SRC_VREG,   SRC_VREG,  DEST_XREG, 8, 9, 19, 0,  0, 0);
        add_row(11, FU_MUL, 4'd2, SRC_VREG,   SRC_VREG,  DEST_VREG, 8, 9, 20, 0,  0, 0);
        add_row(12, FU_ALU, 4'd1, SRC_VREG,   SRC_IMM,   DEST_VREG, 20, 0, 21, 4, 0, 0);

        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;

        for (int k = 0; k < NROWS; k++) begin
            while (full) begin
                @(posedge clk);
                #1;
            end
            drive_row(k);
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            repeat (row_gap[k]) begin
                @(posedge clk);
                #1;
            end
        end

        while (!all_done) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        CHK.final_check();
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
